// ==== rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ROB_DEPTH  = 8;
    localparam int TAG_W      = 3;
    localparam int MD_STEPS   = 32;  // one result bit per iteration

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]      rob_tag_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,  // shift by b[4:0]
        OP_MUL  = 4'd8,  // low word of product
        OP_DIVU = 4'd9,
        OP_REMU = 4'd10
    } op_t;

    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_RUN  = 2'd1,
        MD_DONE = 2'd2
    } md_state_t;

    // ops that go to the shared multi-cycle unit
    function automatic logic is_multi_cycle(op_t op);
        return (op == OP_MUL) || (op == OP_DIVU) || (op == OP_REMU);
    endfunction

endpackage

`default_nettype wire

// ==== dispatch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_unit (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               op_req,
    input  rob_pkg::op_t       op,
    input  rob_pkg::word_t     a,
    input  rob_pkg::word_t     b,
    input  rob_pkg::reg_addr_t dest,
    output logic               op_ack,
    input  logic               full,
    input  rob_pkg::rob_tag_t  alloc_tag,
    output logic               alloc,
    output rob_pkg::reg_addr_t alloc_dest,
    output logic               alu_valid,
    output rob_pkg::rob_tag_t  alu_tag,
    output rob_pkg::word_t     alu_value,
    input  logic               md_busy,
    output logic               md_start,
    output rob_pkg::op_t       md_op,
    output rob_pkg::word_t     md_a,
    output rob_pkg::word_t     md_b,
    output rob_pkg::rob_tag_t  md_tag
);

    rob_pkg::op_t   op_q;
    rob_pkg::word_t a_q;
    rob_pkg::word_t b_q;
    rob_pkg::word_t alu_result;
    logic           held_md;
    logic           md_in_use;
    logic           accept;

    assign held_md = rob_pkg::is_multi_cycle(op_q);

    // md unit only reports busy once it has seen md_start, so cover the gap here
    assign md_in_use = md_busy | md_start | (alloc & held_md);

    assign accept = op_req && !op_ack && !full &&
                    !(rob_pkg::is_multi_cycle(op) && md_in_use);

    always_comb begin
        case (op_q)
            rob_pkg::OP_ADD: alu_result = a_q + b_q;
            rob_pkg::OP_SUB: alu_result = a_q - b_q;
            rob_pkg::OP_AND: alu_result = a_q & b_q;
            rob_pkg::OP_OR:  alu_result = a_q | b_q;
            rob_pkg::OP_XOR: alu_result = a_q ^ b_q;
            rob_pkg::OP_SLL: alu_result = a_q << b_q[4:0];
            default:         alu_result = '0;
        endcase
    end

    // handshake and issue strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_ack    <= 1'b0;
            alloc     <= 1'b0;
            alu_valid <= 1'b0;
            md_start  <= 1'b0;
        end else begin
            if (accept) begin
                op_ack <= 1'b1;
            end else if (!op_req) begin
                op_ack <= 1'b0;  // four-phase return to zero
            end
            alloc     <= accept;
            alu_valid <= alloc & !held_md;
            md_start  <= alloc & held_md;
        end
    end

    // operands captured at acceptance, tb may change them once ack is seen
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= op;
            a_q        <= a;
            b_q        <= b;
            alloc_dest <= dest;
        end
        if (alloc) begin
            alu_tag   <= alloc_tag;
            alu_value <= alu_result;
            md_op     <= op_q;
            md_a      <= a_q;
            md_b      <= b_q;
            md_tag    <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

// ==== mul_div_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module mul_div_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              md_start,
    input  rob_pkg::op_t      md_op,
    input  rob_pkg::word_t    md_a,
    input  rob_pkg::word_t    md_b,
    input  rob_pkg::rob_tag_t md_tag,
    output logic              md_busy,
    output logic              md_valid,
    output rob_pkg::rob_tag_t md_tag_out,
    output rob_pkg::word_t    md_value
);

    rob_pkg::md_state_t                   state;
    logic [$clog2(rob_pkg::MD_STEPS)-1:0] step;
    rob_pkg::op_t                         op_q;
    rob_pkg::rob_tag_t                    tag_q;
    rob_pkg::word_t                       acc;  // product or partial remainder
    rob_pkg::word_t                       opa;  // multiplicand, or dividend/quotient
    rob_pkg::word_t                       opb;  // multiplier, or divisor
    logic                                 b_zero;
    logic                                 is_mul;
    logic [rob_pkg::XLEN:0]               trial;
    logic                                 launch;

    assign launch = (state == rob_pkg::MD_IDLE) && md_start;
    assign is_mul = (op_q == rob_pkg::OP_MUL);

    // restoring step, top bit set means the subtraction went negative
    assign trial = {acc, opa[rob_pkg::XLEN-1]} - {1'b0, opb};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= rob_pkg::MD_IDLE;
            step  <= '0;
        end else begin
            case (state)
                rob_pkg::MD_IDLE: begin
                    if (md_start) begin
                        state <= rob_pkg::MD_RUN;
                        step  <= '0;
                    end
                end
                rob_pkg::MD_RUN: begin
                    step <= step + 1'b1;
                    if (int'(step) == rob_pkg::MD_STEPS - 1) begin
                        state <= rob_pkg::MD_DONE;
                    end
                end
                rob_pkg::MD_DONE: state <= rob_pkg::MD_IDLE;
                default:          state <= rob_pkg::MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            op_q   <= md_op;
            tag_q  <= md_tag;
            b_zero <= (md_b == '0);
            acc    <= '0;
            opa    <= md_a;
            opb    <= md_b;
        end else if (state == rob_pkg::MD_RUN) begin
            if (is_mul) begin
                if (opb[0]) begin
                    acc <= acc + opa;
                end
                opa <= opa << 1;
                opb <= opb >> 1;
            end else if (!trial[rob_pkg::XLEN]) begin
                acc <= trial[rob_pkg::XLEN-1:0];
                opa <= {opa[rob_pkg::XLEN-2:0], 1'b1};
            end else begin
                acc <= {acc[rob_pkg::XLEN-2:0], opa[rob_pkg::XLEN-1]};
                opa <= {opa[rob_pkg::XLEN-2:0], 1'b0};
            end
        end
    end

    assign md_busy    = (state != rob_pkg::MD_IDLE);
    assign md_valid   = (state == rob_pkg::MD_DONE);
    assign md_tag_out = tag_q;

    always_comb begin
        case (op_q)
            rob_pkg::OP_DIVU: md_value = b_zero ? '1 : opa;  // x/0 gives all ones
            default:          md_value = acc;  // product or remainder (dividend for x/0)
        endcase
    end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               alloc,
    input  rob_pkg::reg_addr_t alloc_dest,
    output rob_pkg::rob_tag_t  alloc_tag,
    output logic               full,
    input  logic               alu_valid,
    input  rob_pkg::rob_tag_t  alu_tag,
    input  rob_pkg::word_t     alu_value,
    input  logic               md_valid,
    input  rob_pkg::rob_tag_t  md_tag_out,
    input  rob_pkg::word_t     md_value,
    output logic               commit_valid,
    output rob_pkg::reg_addr_t commit_dest,
    output rob_pkg::word_t     commit_value
);

    rob_pkg::reg_addr_t             dest_q  [rob_pkg::ROB_DEPTH];
    rob_pkg::word_t                 value_q [rob_pkg::ROB_DEPTH];
    logic [rob_pkg::ROB_DEPTH-1:0]  ready_q;
    rob_pkg::rob_tag_t              head;
    rob_pkg::rob_tag_t              tail;
    logic [rob_pkg::TAG_W:0]        count;
    logic                           commit_fire;

    assign alloc_tag   = tail;
    assign full        = (int'(count) == rob_pkg::ROB_DEPTH);
    assign commit_fire = (count != '0) && ready_q[head];

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q      <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc) begin
                ready_q[tail] <= 1'b0;
                tail          <= tail + 1'b1;
            end
            if (alu_valid) begin
                ready_q[alu_tag] <= 1'b1;
            end
            if (md_valid) begin
                ready_q[md_tag_out] <= 1'b1;
            end
            if (commit_fire) begin
                head <= head + 1'b1;
            end
            case ({alloc, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            commit_valid <= commit_fire;
        end
    end

    // both writeback ports can land in one cycle, always on different slots
    always_ff @(posedge clk) begin
        if (alloc) begin
            dest_q[tail] <= alloc_dest;
        end
        if (alu_valid) begin
            value_q[alu_tag] <= alu_value;
        end
        if (md_valid) begin
            value_q[md_tag_out] <= md_value;
        end
        if (commit_fire) begin
            commit_dest  <= dest_q[head];
            commit_value <= value_q[head];
        end
    end

endmodule

`default_nettype wire

// ==== arch_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module arch_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               commit_valid,
    input  rob_pkg::reg_addr_t commit_dest,
    input  rob_pkg::word_t     commit_value,
    input  rob_pkg::reg_addr_t rd_addr,
    output rob_pkg::word_t     rd_data
);

    rob_pkg::word_t regs [2**rob_pkg::REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**rob_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_valid && (commit_dest != '0)) begin
            regs[commit_dest] <= commit_value;  // x0 stays zero
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

`default_nettype wire

// ==== ooo_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               op_req,
    input  rob_pkg::op_t       op,
    input  rob_pkg::word_t     a,
    input  rob_pkg::word_t     b,
    input  rob_pkg::reg_addr_t dest,
    output logic               op_ack,
    output logic               commit_valid,
    output rob_pkg::reg_addr_t commit_dest,
    output rob_pkg::word_t     commit_value,
    input  rob_pkg::reg_addr_t rd_addr,
    output rob_pkg::word_t     rd_data
);

    // allocation
    logic               full;
    logic               alloc;
    rob_pkg::rob_tag_t  alloc_tag;
    rob_pkg::reg_addr_t alloc_dest;

    // alu writeback
    logic               alu_valid;
    rob_pkg::rob_tag_t  alu_tag;
    rob_pkg::word_t     alu_value;

    // multi-cycle unit
    logic               md_busy;
    logic               md_start;
    rob_pkg::op_t       md_op;
    rob_pkg::word_t     md_a;
    rob_pkg::word_t     md_b;
    rob_pkg::rob_tag_t  md_tag;
    logic               md_valid;
    rob_pkg::rob_tag_t  md_tag_out;
    rob_pkg::word_t     md_value;

    dispatch_unit u_dispatch_unit (
        .clk(clk), .arst_n(arst_n),
        .op_req(op_req), .op(op), .a(a), .b(b), .dest(dest), .op_ack(op_ack),
        .full(full), .alloc_tag(alloc_tag), .alloc(alloc), .alloc_dest(alloc_dest),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
        .md_busy(md_busy), .md_start(md_start), .md_op(md_op),
        .md_a(md_a), .md_b(md_b), .md_tag(md_tag)
    );

    mul_div_unit u_mul_div_unit (
        .clk(clk), .arst_n(arst_n),
        .md_start(md_start), .md_op(md_op), .md_a(md_a), .md_b(md_b), .md_tag(md_tag),
        .md_busy(md_busy), .md_valid(md_valid),
        .md_tag_out(md_tag_out), .md_value(md_value)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .arst_n(arst_n),
        .alloc(alloc), .alloc_dest(alloc_dest), .alloc_tag(alloc_tag), .full(full),
        .alu_valid(alu_valid), .alu_tag(alu_tag), .alu_value(alu_value),
        .md_valid(md_valid), .md_tag_out(md_tag_out), .md_value(md_value),
        .commit_valid(commit_valid), .commit_dest(commit_dest),
        .commit_value(commit_value)
    );

    arch_regfile u_arch_regfile (
        .clk(clk), .arst_n(arst_n),
        .commit_valid(commit_valid), .commit_dest(commit_dest),
        .commit_value(commit_value),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

endmodule

`default_nettype wire

// ==== ooo_core_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module ooo_core_props (
    input logic               clk,
    input logic               arst_n,
    input logic               op_req,
    input logic               op_ack,
    input logic               commit_valid,
    input rob_pkg::reg_addr_t rd_addr,
    input rob_pkg::word_t     rd_data
);

    // ack only answers a pending request
    ack_rise_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(op_ack) |-> $past(op_req)
    ) else $error("op_ack rose while op_req was low");

    ack_fall_after_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(op_ack) |-> !$past(op_req)
    ) else $error("op_ack fell while op_req was still high");

    no_commit_in_reset: assert property (
        @(posedge clk) !arst_n |-> !commit_valid
    ) else $error("commit_valid high during reset");

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd_addr == '0) |-> (rd_data == '0)
    ) else $error("x0 read back nonzero");  // x0 hardwired

endmodule

`default_nettype wire

// ==== tb_ooo_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ooo_core;

    localparam int ACK_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 400;

    logic               clk;
    logic               arst_n;
    logic               op_req;
    rob_pkg::op_t       op;
    rob_pkg::word_t     a;
    rob_pkg::word_t     b;
    rob_pkg::reg_addr_t dest;
    logic               op_ack;
    logic               commit_valid;
    rob_pkg::reg_addr_t commit_dest;
    rob_pkg::word_t     commit_value;
    rob_pkg::reg_addr_t rd_addr;
    rob_pkg::word_t     rd_data;

    // reference model, expected commits in acceptance order
    rob_pkg::reg_addr_t exp_dest_q[$];
    rob_pkg::word_t     exp_val_q[$];
    rob_pkg::word_t     model_regs [32];
    int                 accepted_count;
    int                 committed_count;
    int                 max_outstanding;
    logic [31:0]        lcg_state = 32'd59628;

    ooo_core_top DUT (
        .clk(clk), .arst_n(arst_n),
        .op_req(op_req), .op(op), .a(a), .b(b), .dest(dest), .op_ack(op_ack),
        .commit_valid(commit_valid), .commit_dest(commit_dest),
        .commit_value(commit_value),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    bind ooo_core_top ooo_core_props u_props (
        .clk(clk), .arst_n(arst_n), .op_req(op_req), .op_ack(op_ack),
        .commit_valid(commit_valid), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic rob_pkg::word_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};  // low lcg bits are weak
    endfunction

    function automatic rob_pkg::reg_addr_t rand_dest();
        logic [31:0] r;
        r = next_rand();
        return r[31:27];
    endfunction

    function automatic rob_pkg::op_t rand_alu_op();
        logic [31:0] r;
        r = next_rand();
        case (r[30:28])
            3'd0:    return rob_pkg::OP_ADD;
            3'd1:    return rob_pkg::OP_SUB;
            3'd2:    return rob_pkg::OP_AND;
            3'd3:    return rob_pkg::OP_OR;
            3'd4:    return rob_pkg::OP_XOR;
            default: return rob_pkg::OP_SLL;
        endcase
    endfunction

    function automatic rob_pkg::op_t rand_md_op();
        logic [31:0] r;
        r = next_rand();
        case (r[31:30])
            2'd0:    return rob_pkg::OP_MUL;
            2'd1:    return rob_pkg::OP_DIVU;
            default: return rob_pkg::OP_REMU;
        endcase
    endfunction

    // result of one instruction by the ISA rules
    function automatic rob_pkg::word_t expected_result(rob_pkg::op_t op_i,
                                                       rob_pkg::word_t x,
                                                       rob_pkg::word_t y);
        logic [63:0] prod;
        prod = {32'b0, x} * {32'b0, y};
        case (op_i)
            rob_pkg::OP_ADD:  return x + y;
            rob_pkg::OP_SUB:  return x - y;
            rob_pkg::OP_AND:  return x & y;
            rob_pkg::OP_OR:   return x | y;
            rob_pkg::OP_XOR:  return x ^ y;
            rob_pkg::OP_SLL:  return x << y[4:0];
            rob_pkg::OP_MUL:  return prod[31:0];
            rob_pkg::OP_DIVU: return (y == '0) ? 32'hffff_ffff : x / y;
            rob_pkg::OP_REMU: return (y == '0) ? x : x % y;
            default:          return '0;
        endcase
    endfunction

    task automatic stop_on_failure();
        $display("Simulation failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // one four-phase transfer, expectation queued once it is accepted
    task automatic issue(rob_pkg::op_t op_i, rob_pkg::word_t x, rob_pkg::word_t y,
                         rob_pkg::reg_addr_t d);
        int waited;
        @(negedge clk);
        op     = op_i;
        a      = x;
        b      = y;
        dest   = d;
        op_req = 1'b1;
        waited = 0;
        while (!op_ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                $display("timeout: request was not acknowledged within %0d cycles", waited);
                stop_on_failure();
            end
        end
        exp_dest_q.push_back(d);
        exp_val_q.push_back(expected_result(op_i, x, y));
        accepted_count++;
        if (accepted_count - committed_count > rob_pkg::ROB_DEPTH) begin
            $display("more instructions in flight than the reorder buffer can hold");
            stop_on_failure();
        end
        if (accepted_count - committed_count > max_outstanding) begin
            max_outstanding = accepted_count - committed_count;
        end
        op_req = 1'b0;
        waited = 0;
        while (op_ack) begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT) begin
                $display("timeout: op_ack stayed high after the request dropped");
                stop_on_failure();
            end
        end
    endtask

    task automatic issue_random_alu();
        rob_pkg::op_t       op_i;
        rob_pkg::word_t     x;
        rob_pkg::word_t     y;
        rob_pkg::reg_addr_t d;
        op_i = rand_alu_op();
        x    = rand_word();
        y    = rand_word();
        d    = rand_dest();
        issue(op_i, x, y, d);
    endtask

    task automatic monitor_commits();
        rob_pkg::reg_addr_t exp_dest;
        rob_pkg::word_t     exp_val;
        forever begin
            @(negedge clk);
            if (arst_n && commit_valid) begin
                if (exp_dest_q.size() == 0) begin
                    $display("commit seen with no instruction outstanding");
                    stop_on_failure();
                end else begin
                    exp_dest = exp_dest_q.pop_front();
                    exp_val  = exp_val_q.pop_front();
                    check_value("commit_dest", 32'(commit_dest), 32'(exp_dest));
                    check_value("commit_value", commit_value, exp_val);
                    if (exp_dest != '0) begin
                        model_regs[exp_dest] = exp_val;
                    end
                    committed_count++;
                end
            end
        end
    endtask

    initial begin
        rob_pkg::op_t   mop;
        rob_pkg::word_t x;
        rob_pkg::word_t y;
        logic [31:0]    r;
        int             waited;
        arst_n  = 1'b0;
        op_req  = 1'b0;
        op      = rob_pkg::OP_ADD;
        a       = '0;
        b       = '0;
        dest    = '0;
        rd_addr = '0;
        accepted_count  = 0;
        committed_count = 0;
        max_outstanding = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        fork
            monitor_commits();
        join_none

        // random alu traffic, x0 targeted on purpose too
        repeat (40) issue_random_alu();
        issue(rob_pkg::OP_ADD, 32'd5, 32'd7, 5'd0);

        // multi-cycle ops, every fourth divisor zero
        for (int i = 0; i < 12; i++) begin
            mop = rand_md_op();
            x   = rand_word();
            r   = next_rand();
            y   = rand_word() >> r[31:27];
            if (i % 4 == 3) begin
                y = '0;
            end
            issue(mop, x, y, rand_dest());
        end
        issue(rob_pkg::OP_DIVU, 32'hdead_beef, 32'd0, 5'd7);
        issue(rob_pkg::OP_REMU, 32'h1234_5678, 32'd0, 5'd8);
        issue(rob_pkg::OP_MUL, 32'hffff_fff0, 32'd3, 5'd0);

        // slow divide ahead of fast alu ops
        issue(rob_pkg::OP_DIVU, rand_word(), 32'd3, 5'd20);
        for (int i = 0; i < 5; i++) begin
            issue(rand_alu_op(), rand_word(), rand_word(), 5'(21 + i));
        end

        // back-pressure, buffer should fill behind each divide
        max_outstanding = 0;
        repeat (4) begin
            issue(rand_md_op(), rand_word(), rand_word() >> 4, rand_dest());
            repeat (10) issue_random_alu();
        end
        check_value("max_outstanding", 32'(max_outstanding), 32'(rob_pkg::ROB_DEPTH));

        waited = 0;
        while (exp_dest_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                $display("timeout: %0d instructions never committed", exp_dest_q.size());
                stop_on_failure();
            end
        end
        repeat (2) @(negedge clk);

        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            rd_addr = 5'(i);
            @(posedge clk);
            check_value("rd_data", rd_data, model_regs[i]);
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
rob_pkg.sv
dispatch_unit.sv
mul_div_unit.sv
reorder_buffer.sv
arch_regfile.sv
ooo_core_top.sv
ooo_core_props.sv
tb_ooo_core.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_ooo_core \
    -f list.f \
    -o tb_ooo_core \
    && ./obj_dir/tb_ooo_core \
    || { echo "run did not pass"; exit 1; }
